//--- files.f
+incdir+logic
+incdir+tb
logic/lc3b_types.sv
logic/lc3b_isa.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/bp.sv
logic/branch_resolve.sv
logic/lc3b_frontend.sv
tb/lc3b_frontend_tb.sv

//--- logic/bp.sv
`timescale 1ns/10ps

`include "lc3b_defines.svh"

module bp (
	input logic clk,
	input lc3b_types::lc3b_control_word incoming_control_word,
	input lc3b_types::lc3b_control_word outgoing_control_word,
	input logic branch_enable,
	input logic incoming_valid_branch,
	input logic outgoing_valid_branch,
	input logic [1:0] outgoing_pcmux_sel,

	output lc3b_types::lc3b_control_word if_control_word,
	output logic [1:0] pcmux_sel,
	output logic flush,
	output logic bp_miss,
	output logic stall
);

	import lc3b_types::*;

	logic ex_redirect;

	always_comb begin
		if_control_word = incoming_control_word;

		// the word entering resolve is looked at by its own opcode.
		case (outgoing_control_word.opcode)
			op_br: begin
				// a taken branch that was guessed not taken is a miss.
				ex_redirect = outgoing_valid_branch && branch_enable &&
					!outgoing_control_word.predicted_branch;
			end
			op_jmp, op_jsr, op_trap: begin
				ex_redirect = outgoing_valid_branch; // always a miss under not-taken.
			end
			default: begin
				ex_redirect = 1'b0;
			end
		endcase

		// decode side: every transfer is guessed not taken.
		case (incoming_control_word.opcode)
			op_br: begin
				if_control_word.predicted_branch = 1'b0;
				stall = 1'b0;
			end
			op_jmp, op_jsr, op_trap: begin
				if_control_word.predicted_branch = 1'b0;
				stall = incoming_valid_branch; // hold fetch until the target is known.
			end
			default: begin
				stall = 1'b0;
			end
		endcase

		// An instruction squashed by an older redirect must not hold fetch.
		if (ex_redirect)
			stall = 1'b0;

		flush = ex_redirect;
		bp_miss = ex_redirect; // every redirect means the guess was wrong.
		pcmux_sel = ex_redirect ? outgoing_pcmux_sel : `PCMUX_NEXT;
	end

endmodule : bp

//--- logic/branch_resolve.sv
`timescale 1ns/10ps

`include "lc3b_defines.svh"

module branch_resolve (
	input logic clk,
	input logic reset,
	input logic flush,
	input lc3b_types::lc3b_control_word if_control_word,
	input lc3b_isa::lc3b_instr id_instr,
	input logic [2:0] cc_nzp,
	input logic [`LC3B_WORD_WIDTH-1:0] reg_rdata,
	output lc3b_types::lc3b_control_word outgoing_control_word,
	output logic outgoing_valid_branch,
	output logic branch_enable,
	output logic [1:0] outgoing_pcmux_sel,
	output logic [2:0] reg_addr,
	output logic [`LC3B_WORD_WIDTH-1:0] branch_target,
	output logic [`LC3B_WORD_WIDTH-1:0] baser_value,
	output logic [`LC3B_WORD_WIDTH-1:0] trap_target,
	output logic ex_valid,
	output lc3b_types::lc3b_opcode ex_opcode,
	output logic [`LC3B_WORD_WIDTH-1:0] ex_pc
);

	import lc3b_types::*;
	import lc3b_isa::*;

	lc3b_control_word ex_cw;
	lc3b_instr ex_instr;
	logic ex_valid_q;
	logic [`LC3B_WORD_WIDTH-1:0] ex_pc_plus2;
	logic [`LC3B_WORD_WIDTH-1:0] offset9_ext;
	logic [`LC3B_WORD_WIDTH-1:0] offset11_ext;

	// ID/EX register. flush drops whatever decode holds.
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			ex_valid_q <= 1'b0;
		end else begin
			ex_valid_q <= if_control_word.valid;
		end
	end

	always_ff @(posedge clk) begin
		ex_cw <= if_control_word;
		ex_instr <= id_instr;
	end

	always_comb begin
		outgoing_control_word = ex_cw;
		outgoing_control_word.valid = ex_valid_q;
	end

	assign outgoing_valid_branch = ex_valid_q;
	assign branch_enable = |(ex_cw.nzp & cc_nzp);

	// word offsets, sign extended and scaled to bytes.
	assign offset9_ext = {{6{ex_instr.br_fmt.pcoffset9[8]}}, ex_instr.br_fmt.pcoffset9, 1'b0};
	assign offset11_ext = {{4{ex_instr.jsr_fmt.pcoffset11[10]}},
		ex_instr.jsr_fmt.pcoffset11, 1'b0};
	assign ex_pc_plus2 = ex_cw.pc + `LC3B_WORD_WIDTH'd2;

	assign branch_target = ex_pc_plus2 +
		((ex_cw.opcode == op_jsr) ? offset11_ext : offset9_ext);
	assign trap_target = {7'b0, ex_instr.trap_fmt.trapvect8, 1'b0};
	assign reg_addr = ex_instr.jmp_fmt.baser;
	assign baser_value = reg_rdata; // register file answers in the same cycle.

	always_comb begin
		case (ex_cw.opcode)
			op_br, op_jsr: outgoing_pcmux_sel = `PCMUX_BRANCH;
			op_jmp:        outgoing_pcmux_sel = `PCMUX_BASER;
			op_trap:       outgoing_pcmux_sel = `PCMUX_TRAP;
			default:       outgoing_pcmux_sel = `PCMUX_NEXT;
		endcase
	end

	assign ex_valid = ex_valid_q;
	assign ex_opcode = ex_cw.opcode;
	assign ex_pc = ex_cw.pc;

endmodule : branch_resolve

//--- logic/decode_unit.sv
`timescale 1ns/10ps

`include "lc3b_defines.svh"

module decode_unit (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input logic [`LC3B_WORD_WIDTH-1:0] imem_addr,
	input lc3b_isa::lc3b_instr imem_rdata,
	output lc3b_isa::lc3b_instr id_instr,
	output lc3b_types::lc3b_control_word incoming_control_word,
	output logic incoming_valid_branch
);

	import lc3b_types::*;
	import lc3b_isa::*;

	logic [`LC3B_WORD_WIDTH-1:0] id_pc;
	logic id_valid;

	// IF/ID register. a stall or a flush turns the slot into a bubble.
	always_ff @(posedge clk) begin
		if (reset) begin
			id_valid <= 1'b0;
		end else begin
			id_valid <= !(flush || stall);
		end
	end

	always_ff @(posedge clk) begin
		id_instr <= imem_rdata;
		id_pc <= imem_addr;
	end

	always_comb begin
		incoming_control_word.opcode = id_instr.br_fmt.opcode; // same bits in every view.
		incoming_control_word.pc = id_pc;
		incoming_control_word.nzp = 3'b000;
		incoming_control_word.predicted_branch = 1'b0;
		incoming_control_word.valid = id_valid;
		if (id_instr.br_fmt.opcode == op_br)
			incoming_control_word.nzp = id_instr.br_fmt.nzp; // only BR carries a condition.
	end

	assign incoming_valid_branch = id_valid;

endmodule : decode_unit

//--- logic/fetch_unit.sv
`timescale 1ns/10ps

`include "lc3b_defines.svh"

module fetch_unit (
	input logic clk,
	input logic reset,
	input logic [1:0] pcmux_sel,
	input logic stall,
	input logic flush,
	input logic [`LC3B_WORD_WIDTH-1:0] branch_target,
	input logic [`LC3B_WORD_WIDTH-1:0] baser_value,
	input logic [`LC3B_WORD_WIDTH-1:0] trap_target,
	output logic [`LC3B_WORD_WIDTH-1:0] imem_addr
);

	logic [`LC3B_WORD_WIDTH-1:0] pc;
	logic [`LC3B_WORD_WIDTH-1:0] pc_plus2;
	logic [`LC3B_WORD_WIDTH-1:0] redirect_pc;

	assign pc_plus2 = pc + `LC3B_WORD_WIDTH'd2;

	// the redirect target only matters while flush is high.
	always_comb begin
		case (pcmux_sel)
			`PCMUX_BRANCH: redirect_pc = branch_target;
			`PCMUX_BASER:  redirect_pc = baser_value;
			`PCMUX_TRAP:   redirect_pc = trap_target;
			default:       redirect_pc = pc_plus2;
		endcase
	end

	// flush wins over stall, since the stalled instruction is being squashed.
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `LC3B_RESET_PC;
		end else if (flush) begin
			pc <= redirect_pc;
		end else if (!stall) begin
			pc <= pc_plus2;
		end
	end

	assign imem_addr = pc; // memory answers in the same cycle.

endmodule : fetch_unit

//--- logic/lc3b_defines.svh
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// width of the PC, instruction addresses and data words.
`define LC3B_WORD_WIDTH 16

// address of the first instruction fetched after reset.
`define LC3B_RESET_PC 16'h0000

// pcmux select codes, shared by the predictor, fetch and resolve.
`define PCMUX_NEXT   2'b00 // sequential pc + 2.
`define PCMUX_BRANCH 2'b01 // pc-relative target of BR or JSR.
`define PCMUX_BASER  2'b10 // base register value for JMP.
`define PCMUX_TRAP   2'b11 // trap vector table entry.

`endif

//--- logic/lc3b_frontend.sv
`timescale 1ns/10ps

`include "lc3b_defines.svh"

module lc3b_frontend (
	input logic clk,
	input logic reset,
	input lc3b_isa::lc3b_instr imem_rdata,
	input logic [2:0] cc_nzp,
	input logic [`LC3B_WORD_WIDTH-1:0] reg_rdata,
	output logic [`LC3B_WORD_WIDTH-1:0] imem_addr,
	output logic [2:0] reg_addr,
	output logic flush,
	output logic stall,
	output logic bp_miss,
	output logic ex_valid,
	output logic [`LC3B_WORD_WIDTH-1:0] ex_pc,
	output lc3b_types::lc3b_opcode ex_opcode
);

	import lc3b_types::*;
	import lc3b_isa::*;

	// redirect path from resolve back to fetch.
	logic [1:0] pcmux_sel;
	logic [`LC3B_WORD_WIDTH-1:0] branch_target;
	logic [`LC3B_WORD_WIDTH-1:0] baser_value;
	logic [`LC3B_WORD_WIDTH-1:0] trap_target;

	// decode and resolve traffic through the predictor.
	lc3b_instr id_instr;
	lc3b_control_word incoming_control_word;
	lc3b_control_word if_control_word;
	lc3b_control_word outgoing_control_word;
	logic incoming_valid_branch;
	logic outgoing_valid_branch;
	logic branch_enable;
	logic [1:0] outgoing_pcmux_sel;

	fetch_unit fetch_i (
		.clk(clk),
		.reset(reset),
		.pcmux_sel(pcmux_sel),
		.stall(stall),
		.flush(flush),
		.branch_target(branch_target),
		.baser_value(baser_value),
		.trap_target(trap_target),
		.imem_addr(imem_addr)
	);

	decode_unit decode_i (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.flush(flush),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.id_instr(id_instr),
		.incoming_control_word(incoming_control_word),
		.incoming_valid_branch(incoming_valid_branch)
	);

	bp bp_i (
		.clk(clk),
		.incoming_control_word(incoming_control_word),
		.outgoing_control_word(outgoing_control_word),
		.branch_enable(branch_enable),
		.incoming_valid_branch(incoming_valid_branch),
		.outgoing_valid_branch(outgoing_valid_branch),
		.outgoing_pcmux_sel(outgoing_pcmux_sel),
		.if_control_word(if_control_word),
		.pcmux_sel(pcmux_sel),
		.flush(flush),
		.bp_miss(bp_miss),
		.stall(stall)
	);

	branch_resolve resolve_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.if_control_word(if_control_word),
		.id_instr(id_instr),
		.cc_nzp(cc_nzp),
		.reg_rdata(reg_rdata),
		.outgoing_control_word(outgoing_control_word),
		.outgoing_valid_branch(outgoing_valid_branch),
		.branch_enable(branch_enable),
		.outgoing_pcmux_sel(outgoing_pcmux_sel),
		.reg_addr(reg_addr),
		.branch_target(branch_target),
		.baser_value(baser_value),
		.trap_target(trap_target),
		.ex_valid(ex_valid),
		.ex_opcode(ex_opcode),
		.ex_pc(ex_pc)
	);

endmodule : lc3b_frontend

//--- logic/lc3b_isa.sv
package lc3b_isa;

	// conditional branch: BRnzp pcoffset9.
	typedef struct packed {
		lc3b_types::lc3b_opcode opcode;
		logic [2:0] nzp;
		logic [8:0] pcoffset9;
	} lc3b_br_t;

	// register-indirect jump, also RET when baser is R7.
	typedef struct packed {
		lc3b_types::lc3b_opcode opcode;
		logic [2:0] unused_hi;
		logic [2:0] baser;
		logic [5:0] unused_lo;
	} lc3b_jmp_t;

	// subroutine call with a long pc-relative offset.
	typedef struct packed {
		lc3b_types::lc3b_opcode opcode;
		logic long_flag; // set for JSR, clear for JSRR.
		logic [10:0] pcoffset11;
	} lc3b_jsr_t;

	// system call through the trap vector table.
	typedef struct packed {
		lc3b_types::lc3b_opcode opcode;
		logic [3:0] unused;
		logic [7:0] trapvect8;
	} lc3b_trap_t;

	// one instruction word, read through whichever format its opcode implies.
	typedef union packed {
		lc3b_br_t br_fmt;
		lc3b_jmp_t jmp_fmt;
		lc3b_jsr_t jsr_fmt;
		lc3b_trap_t trap_fmt;
	} lc3b_instr;

endpackage : lc3b_isa

//--- logic/lc3b_types.sv
package lc3b_types;

`include "lc3b_defines.svh"

	// the sixteen LC-3b opcodes, encoded as in instruction bits [15:12].
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// control word carried from decode into the resolve stage.
	typedef struct packed {
		lc3b_opcode opcode;
		logic [`LC3B_WORD_WIDTH-1:0] pc; // address of the instruction itself.
		logic [2:0] nzp;
		logic predicted_branch;
		logic valid;
	} lc3b_control_word;

endpackage : lc3b_types

//--- run.sh
#!/bin/sh
# build the frontend testbench with Verilator, run it, then scan the log for the fail line.

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
	--top-module lc3b_frontend_tb -f files.f -o sim_frontend > build.log 2>&1 \
	&& ./obj_dir/sim_frontend > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log

! grep -q "Simulation finished: FAIL" sim.log \
	&& echo "run passed" \
	|| { echo "run failed, see sim.log"; exit 1; }

//--- tb/frontend_model.svh
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

	localparam int IMEM_WORDS = 96;
	localparam int REGION_BASE = 32; // first word of the random code region.

	logic [15:0] imem_image [IMEM_WORDS];
	logic [15:0] reg_image [8];

	function automatic logic [15:0] encode_br(input logic [2:0] nzp, input logic [8:0] offset9);
		return {op_br, nzp, offset9};
	endfunction

	function automatic logic [15:0] encode_jmp(input logic [2:0] baser);
		return {op_jmp, 3'b000, baser, 6'b000000};
	endfunction

	function automatic logic [15:0] encode_jsr(input logic [10:0] offset11);
		return {op_jsr, 1'b1, offset11};
	endfunction

	function automatic logic [15:0] encode_trap(input logic [7:0] trapvect8);
		return {op_trap, 4'b0000, trapvect8};
	endfunction

	// words beyond the image read as ADDs whose bits follow the address.
	function automatic logic [15:0] fetch_word(input logic [15:0] addr);
		int word_index;
		word_index = {17'd0, addr[15:1]};
		if (word_index < IMEM_WORDS)
			return imem_image[word_index];
		return {op_add, addr[15:4] ^ addr[11:0]};
	endfunction

	function automatic logic holds_fetch(input lc3b_instr instr);
		case (instr.br_fmt.opcode)
			op_jmp, op_jsr, op_trap: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic redirects_fetch(input lc3b_instr instr, input logic [2:0] cc);
		if (instr.br_fmt.opcode == op_br)
			return |(instr.br_fmt.nzp & cc);
		return holds_fetch(instr);
	endfunction

	// architectural successor of one instruction under the given condition codes.
	function automatic logic [15:0] predict_next_pc(input lc3b_instr instr,
		input logic [15:0] addr, input logic [2:0] cc);
		logic [15:0] seq_pc;
		seq_pc = addr + 16'd2;
		case (instr.br_fmt.opcode)
			op_br: begin
				if (|(instr.br_fmt.nzp & cc))
					return seq_pc + (16'($signed(instr.br_fmt.pcoffset9)) << 1);
				return seq_pc;
			end
			op_jsr: return seq_pc + (16'($signed(instr.jsr_fmt.pcoffset11)) << 1);
			op_jmp: return reg_image[instr.jmp_fmt.baser];
			op_trap: return {8'd0, instr.trap_fmt.trapvect8} << 1;
			default: return seq_pc;
		endcase
	endfunction

	task automatic load_program();
		logic [31:0] r;
		int i;
		int offset;
		for (i = 0; i < IMEM_WORDS; i++) begin
			r = $random(seed);
			imem_image[i] = {op_add, r[11:0]};
			if (i >= REGION_BASE && r[14:12] < 3'd2) begin
				offset = REGION_BASE + {26'd0, r[21:16]} - (i + 1); // target stays in the region.
				imem_image[i] = encode_br(r[24:22], offset[8:0]);
			end
		end
		imem_image[3] = encode_br(3'b000, 9'd5); // never taken.
		imem_image[5] = encode_br(3'b111, 9'd2); // always taken, to word 8.
		imem_image[6] = encode_jmp(3'd5); // squashed by the branch above.
		imem_image[7] = encode_trap(8'h40);
		imem_image[8] = encode_jmp(3'd1);
		imem_image[16] = encode_jsr(11'd3);
		imem_image[17] = encode_jmp(3'd6); // squashed by the JSR.
		imem_image[20] = encode_trap(8'h18);
		imem_image[24] = encode_jmp(3'd2);
		imem_image[25] = encode_br(3'b111, 9'h1f0);
		offset = 40 - 61;
		imem_image[60] = encode_jsr(offset[10:0]);
		imem_image[70] = encode_trap(8'h20);
		imem_image[IMEM_WORDS - 1] = encode_jmp(3'd3); // loops back into the region.
		reg_image[0] = 16'h0000;
		reg_image[1] = 16'h0020;
		reg_image[2] = 16'h0040;
		reg_image[3] = 16'h0048;
		reg_image[4] = 16'h0050;
		reg_image[5] = 16'h0060;
		reg_image[6] = 16'h0070;
		reg_image[7] = 16'h0080;
	endtask

`endif

//--- tb/lc3b_frontend_tb.sv
`timescale 1ns/10ps

`include "lc3b_defines.svh"

module lc3b_frontend_tb;

	import lc3b_types::*;
	import lc3b_isa::*;

	localparam int RESET_CYCLES = 5;

	logic clk = 1'b0;
	logic reset;
	lc3b_instr imem_rdata;
	logic [2:0] cc_nzp;
	logic [15:0] reg_rdata;
	logic [15:0] imem_addr;
	logic [2:0] reg_addr;
	logic flush;
	logic stall;
	logic bp_miss;
	logic ex_valid;
	logic [15:0] ex_pc;
	lc3b_opcode ex_opcode;

	integer seed;
	int errors = 0;
	int checks = 0;
	int cycle = 0; // cycles checked since reset was released.
	int waited;

	`include "frontend_model.svh"

	localparam int TRACE_CYCLES = 3 * IMEM_WORDS;
	localparam int TIMEOUT_CYCLES = 4 * IMEM_WORDS + RESET_CYCLES;

	// expected outputs per cycle, with spare slots for the pipeline depth.
	logic [15:0] exp_addr [TRACE_CYCLES + 3];
	logic exp_flush [TRACE_CYCLES + 3];
	logic exp_stall [TRACE_CYCLES + 3];
	logic exp_ex_valid [TRACE_CYCLES + 3];
	logic [15:0] exp_ex_pc [TRACE_CYCLES + 3];
	logic [15:0] exp_ex_word [TRACE_CYCLES + 3];
	logic [2:0] cc_sched [TRACE_CYCLES + 3];

	lc3b_frontend dut_i (
		.clk(clk),
		.reset(reset),
		.imem_rdata(imem_rdata),
		.cc_nzp(cc_nzp),
		.reg_rdata(reg_rdata),
		.imem_addr(imem_addr),
		.reg_addr(reg_addr),
		.flush(flush),
		.stall(stall),
		.bp_miss(bp_miss),
		.ex_valid(ex_valid),
		.ex_pc(ex_pc),
		.ex_opcode(ex_opcode)
	);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL at %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
		end
	endtask

	task automatic build_cc_schedule();
		logic [31:0] r;
		int k;
		for (k = 0; k < TRACE_CYCLES + 3; k++) begin
			r = $random(seed);
			case (r[1:0])
				2'd0: cc_sched[k] = 3'b100;
				2'd1: cc_sched[k] = 3'b010;
				default: cc_sched[k] = 3'b001;
			endcase
		end
	endtask

	// walks the program in order and lays each instruction's effects onto the cycle trace.
	task automatic build_expected_trace();
		logic [15:0] pc;
		logic [15:0] word;
		logic [2:0] cc;
		int c;
		int k;
		for (k = 0; k < TRACE_CYCLES + 3; k++) begin
			exp_addr[k] = 16'h0000;
			exp_flush[k] = 1'b0;
			exp_stall[k] = 1'b0;
			exp_ex_valid[k] = 1'b0;
			exp_ex_pc[k] = 16'h0000;
			exp_ex_word[k] = 16'h0000;
		end
		c = 0;
		pc = `LC3B_RESET_PC;
		while (c < TRACE_CYCLES) begin
			word = fetch_word(pc);
			cc = cc_sched[c + 2]; // conditions seen when the word resolves.
			exp_addr[c] = pc;
			exp_ex_valid[c + 2] = 1'b1;
			exp_ex_pc[c + 2] = pc;
			exp_ex_word[c + 2] = word;
			if (holds_fetch(word)) begin
				exp_addr[c + 1] = pc + 16'd2;
				exp_stall[c + 1] = 1'b1;
				exp_addr[c + 2] = pc + 16'd2;
				exp_flush[c + 2] = 1'b1;
				c = c + 3;
			end else if (redirects_fetch(word, cc)) begin
				exp_addr[c + 1] = pc + 16'd2;
				exp_addr[c + 2] = pc + 16'd4;
				exp_flush[c + 2] = 1'b1;
				c = c + 3;
			end else begin
				c = c + 1;
			end
			pc = predict_next_pc(word, pc, cc);
		end
	endtask

	// memory, register file and condition codes answer on the falling edge.
	always @(negedge clk) begin
		imem_rdata = fetch_word(imem_addr);
		reg_rdata = reg_image[reg_addr];
		cc_nzp = cc_sched[cycle];
	end

	always @(posedge clk) begin
		if (!reset && cycle < TRACE_CYCLES) begin
			check_value("imem_addr", exp_addr[cycle], imem_addr);
			check_value("flush", {15'd0, exp_flush[cycle]}, {15'd0, flush});
			check_value("stall", {15'd0, exp_stall[cycle]}, {15'd0, stall});
			// every flush is a miss.
			check_value("bp_miss", {15'd0, exp_flush[cycle]}, {15'd0, bp_miss});
			check_value("ex_valid", {15'd0, exp_ex_valid[cycle]}, {15'd0, ex_valid});
			if (exp_ex_valid[cycle]) begin
				check_value("ex_pc", exp_ex_pc[cycle], ex_pc);
				check_value("ex_opcode", {12'd0, exp_ex_word[cycle][15:12]}, {12'd0, ex_opcode});
				if (exp_ex_word[cycle][15:12] == op_jmp)
					check_value("reg_addr", {13'd0, exp_ex_word[cycle][8:6]}, {13'd0, reg_addr});
			end
			cycle = cycle + 1;
		end
	end

	initial begin
		seed = 32'hc56b;
		reset = 1'b1;
		imem_rdata = '0;
		cc_nzp = 3'b000;
		reg_rdata = 16'h0000;
		load_program();
		build_cc_schedule();
		build_expected_trace();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		waited = RESET_CYCLES;
		while (cycle < TRACE_CYCLES && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (cycle < TRACE_CYCLES)
			$display("ERROR: the run timed out after %0d cycles, only %0d of %0d cycles checked",
				waited, cycle, TRACE_CYCLES);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && cycle >= TRACE_CYCLES)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule : lc3b_frontend_tb
